// File: flist.f
hw/etx_pkg.sv
hw/etx_arbiter.sv
hw/etx_cfg.sv
hw/etx_remap.sv
hw/etx_protocol.sv
hw/etx_core.sv
test/etx_core_tb.sv

// File: hw/etx_arbiter.sv
`timescale 1ns/10ps

module etx_arbiter
   import etx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   // Write channel
   input  logic        txwr_valid,
   input  etx_packet_t txwr_packet,
   output logic        txwr_ready,
   // Read request channel
   input  logic        txrd_valid,
   input  etx_packet_t txrd_packet,
   output logic        txrd_ready,
   // Read response channel
   input  logic        txrr_valid,
   input  etx_packet_t txrr_packet,
   output logic        txrr_ready,
   // Control mode override from the register file
   input  logic        ctrl_override,
   input  ctrlmode_t   ctrl_mode,
   // Toward etx_cfg
   output logic        arb_valid,
   output etx_item_t   arb_item,
   input  logic        arb_ready
);

   etx_chan_e   grant;                          // Winning channel this cycle
   logic        load;                           // Output register can take an item
   logic        any_valid;                      // Some channel is requesting
   etx_packet_t sel_packet;                     // Granted packet after override

   assign load      = ~arb_valid | arb_ready;   // Empty or draining now
   assign any_valid = txrr_valid | txwr_valid | txrd_valid;

   // Fixed priority, responses never wait behind new requests
   always_comb begin
      grant = CHAN_RD;                          // Lowest priority by default
      if (txrr_valid) begin
         grant = CHAN_RR;
      end else if (txwr_valid) begin
         grant = CHAN_WR;
      end
   end

   // Only the granted channel is offered a ready
   assign txrr_ready = load & (grant == CHAN_RR);
   assign txwr_ready = load & (grant == CHAN_WR);
   assign txrd_ready = load & (grant == CHAN_RD);

   always_comb begin
      case (grant)
         CHAN_RR: sel_packet = txrr_packet;
         CHAN_WR: sel_packet = txwr_packet;
         default: sel_packet = txrd_packet;
      endcase
      if (ctrl_override) begin
         sel_packet.ctrlmode = ctrl_mode;       // Force mode on every packet
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arb_valid <= 1'b0;
      end else if (load) begin
         arb_valid <= any_valid;                // Refill or go empty
      end
   end

   // Payload only, qualified by arb_valid
   always_ff @(posedge clk) begin
      if (load & any_valid) begin
         arb_item.is_rr <= (grant == CHAN_RR);  // Tag responses for remap bypass
         arb_item.pkt   <= sel_packet;
      end
   end

endmodule

// File: hw/etx_cfg.sv
`timescale 1ns/10ps

module etx_cfg
   import etx_pkg::*;
#(
   parameter logic [11:0] ID = 12'h810          // Core ID in dstaddr[31:20]
) (
   input  logic        clk,
   input  logic        rst_n,
   // From the arbiter
   input  logic        arb_valid,
   input  etx_item_t   arb_item,
   output logic        arb_ready,
   // Pass-through toward remap
   output logic        cfg_item_valid,
   output etx_item_t   cfg_item,
   input  logic        cfg_item_ready,
   // Register read responses toward the receiver
   output logic        cfg_valid,
   output etx_packet_t cfg_packet,
   input  logic        cfg_ready,
   // Register outputs
   output logic        tx_enable,
   output logic        remap_enable,
   output logic        ctrl_override,
   output ctrlmode_t   ctrl_mode,
   output addr_t       remap_mask,
   output addr_t       remap_pat
);

   logic     is_reg;                            // Item targets the register space
   reg_idx_t reg_idx;                           // Addressed register
   logic     pass_load;                         // Pass register can load
   logic     rsp_load;                          // Response register can load
   logic     accept;                            // Item taken from the arbiter
   data_t    reg_rdata;                         // Readback mux
   data_t    tx_count;                          // REG_COUNT

   assign is_reg  = ~arb_item.is_rr
                  & (arb_item.pkt.dstaddr[31:20] == ID)
                  & (arb_item.pkt.dstaddr[19:16] == CFG_REGION);
   assign reg_idx = arb_item.pkt.dstaddr[3:2];

   assign pass_load = ~cfg_item_valid | cfg_item_ready;
   assign rsp_load  = ~cfg_valid | cfg_ready;

   // Writes always land, reads need room for the response
   assign arb_ready = is_reg ? (arb_item.pkt.write | rsp_load) : pass_load;
   assign accept    = arb_valid & arb_ready;

   always_comb begin
      case (reg_idx)
         REG_CTRL:       reg_rdata = {24'b0, ctrl_mode, 1'b0, ctrl_override,
                                      remap_enable, tx_enable};
         REG_REMAP_MASK: reg_rdata = remap_mask;
         REG_REMAP_PAT:  reg_rdata = remap_pat;
         default:        reg_rdata = tx_count;  // REG_COUNT
      endcase
   end

   // Register file and valid flags
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_enable      <= 1'b0;
         remap_enable   <= 1'b0;
         ctrl_override  <= 1'b0;
         ctrl_mode      <= '0;
         remap_mask     <= '0;
         remap_pat      <= '0;
         tx_count       <= '0;
         cfg_item_valid <= 1'b0;
         cfg_valid      <= 1'b0;
      end else begin
         if (accept & is_reg & arb_item.pkt.write) begin
            case (reg_idx)
               REG_CTRL: begin
                  tx_enable     <= arb_item.pkt.data[0];
                  remap_enable  <= arb_item.pkt.data[1];
                  ctrl_override <= arb_item.pkt.data[2];
                  ctrl_mode     <= arb_item.pkt.data[7:4];
               end
               REG_REMAP_MASK: remap_mask <= arb_item.pkt.data;
               REG_REMAP_PAT:  remap_pat  <= arb_item.pkt.data;
               default: ;                       // REG_COUNT ignores writes
            endcase
         end
         if (accept & ~is_reg) begin
            tx_count <= tx_count + 32'd1;       // Wraps at 32 bits
         end
         if (pass_load) begin
            cfg_item_valid <= arb_valid & ~is_reg;
         end
         if (rsp_load) begin
            cfg_valid <= arb_valid & is_reg & ~arb_item.pkt.write;
         end
      end
   end

   // Payload registers
   always_ff @(posedge clk) begin
      if (accept & ~is_reg) begin
         cfg_item <= arb_item;
      end
      if (accept & is_reg & ~arb_item.pkt.write) begin
         cfg_packet         <= arb_item.pkt;    // Keep modes and srcaddr
         cfg_packet.write   <= 1'b1;            // Response is a write
         cfg_packet.dstaddr <= arb_item.pkt.srcaddr;
         cfg_packet.data    <= reg_rdata;
      end
   end

endmodule

// File: hw/etx_core.sv
`timescale 1ns/10ps

module etx_core
   import etx_pkg::*;
#(
   parameter logic [11:0] ID         = 12'h810, // Core ID for the register space
   parameter addr_t       BURST_STEP = 32'd4    // Burst address increment
) (
   input  logic        clk,
   input  logic        rst_n,
   // Write channel
   input  logic        txwr_valid,
   input  etx_packet_t txwr_packet,
   output logic        txwr_ready,
   // Read request channel
   input  logic        txrd_valid,
   input  etx_packet_t txrd_packet,
   output logic        txrd_ready,
   // Read response channel
   input  logic        txrr_valid,
   input  etx_packet_t txrr_packet,
   output logic        txrr_ready,
   // Link port
   output logic        tx_valid,
   output etx_packet_t tx_packet,
   output logic        tx_burst,
   input  logic        tx_wr_ready,
   input  logic        tx_rd_ready,
   // Register read responses toward the receiver
   output logic        cfg_valid,
   output etx_packet_t cfg_packet,
   input  logic        cfg_ready
);

   logic      arb_valid, arb_ready;              // Arbiter to cfg
   etx_item_t arb_item;
   logic      cfg_item_valid, cfg_item_ready;    // Cfg to remap
   etx_item_t cfg_item;
   logic      remap_valid, remap_ready;          // Remap to protocol
   etx_item_t remap_item;
   logic      tx_enable, remap_enable, ctrl_override;
   ctrlmode_t ctrl_mode;
   addr_t     remap_mask, remap_pat;

   etx_arbiter u_arbiter (
      .clk, .rst_n,
      .txwr_valid, .txwr_packet, .txwr_ready,
      .txrd_valid, .txrd_packet, .txrd_ready,
      .txrr_valid, .txrr_packet, .txrr_ready,
      .ctrl_override, .ctrl_mode,
      .arb_valid, .arb_item, .arb_ready
   );

   etx_cfg #(.ID(ID)) u_cfg (
      .clk, .rst_n,
      .arb_valid, .arb_item, .arb_ready,
      .cfg_item_valid, .cfg_item, .cfg_item_ready,
      .cfg_valid, .cfg_packet, .cfg_ready,
      .tx_enable, .remap_enable, .ctrl_override, .ctrl_mode,
      .remap_mask, .remap_pat
   );

   etx_remap u_remap (
      .clk, .rst_n,
      .cfg_item_valid, .cfg_item, .cfg_item_ready,
      .remap_enable, .remap_mask, .remap_pat,
      .remap_valid, .remap_item, .remap_ready
   );

   etx_protocol #(.BURST_STEP(BURST_STEP)) u_protocol (
      .clk, .rst_n,
      .remap_valid, .remap_item, .remap_ready,
      .tx_enable,
      .tx_valid, .tx_packet, .tx_burst,
      .tx_wr_ready, .tx_rd_ready
   );

endmodule

// File: hw/etx_pkg.sv
package etx_pkg;

   typedef logic [31:0] addr_t;                 // Destination and source address
   typedef logic [31:0] data_t;                 // Payload word
   typedef logic [3:0]  ctrlmode_t;             // Mesh control mode
   typedef logic [1:0]  datamode_t;             // Transfer size
   typedef logic [1:0]  reg_idx_t;              // Register index from dstaddr[3:2]

   localparam datamode_t DATAMODE_WORD = 2'd2;  // 32-bit transfer

   // Mesh packet, write sits in bit 0 and srcaddr in the top bits
   typedef struct packed {
      addr_t     srcaddr;                       // Bits 102:71
      data_t     data;                          // Bits 70:39
      addr_t     dstaddr;                       // Bits 38:7
      ctrlmode_t ctrlmode;                      // Bits 6:3
      datamode_t datamode;                      // Bits 2:1
      logic      write;                         // Bit 0
   } etx_packet_t;

   // Packet as it moves between the internal stages
   typedef struct packed {
      logic        is_rr;                       // Read-response traffic
      etx_packet_t pkt;
   } etx_item_t;

   localparam logic [3:0] CFG_REGION = 4'hF;    // dstaddr[19:16] of the register space

   localparam reg_idx_t REG_CTRL       = 2'd0;  // Enables, override and ctrl mode
   localparam reg_idx_t REG_REMAP_MASK = 2'd1;  // Bits replaced by remap
   localparam reg_idx_t REG_REMAP_PAT  = 2'd2;  // Replacement pattern
   localparam reg_idx_t REG_COUNT      = 2'd3;  // Pass-through count, read only

   // Granted channel, listed in priority order
   typedef enum logic [1:0] {
      CHAN_RR = 2'd0,                           // Read response
      CHAN_WR = 2'd1,                           // Write
      CHAN_RD = 2'd2                            // Read request
   } etx_chan_e;

endpackage

// File: hw/etx_protocol.sv
`timescale 1ns/10ps

module etx_protocol
   import etx_pkg::*;
#(
   parameter addr_t BURST_STEP = 32'd4          // Address step between burst words
) (
   input  logic        clk,
   input  logic        rst_n,
   // From remap
   input  logic        remap_valid,
   input  etx_item_t   remap_item,
   output logic        remap_ready,
   // From the register file
   input  logic        tx_enable,
   // Link port
   output logic        tx_valid,
   output etx_packet_t tx_packet,
   output logic        tx_burst,
   input  logic        tx_wr_ready,
   input  logic        tx_rd_ready
);

   logic  drain;                                // Held packet leaves this cycle
   logic  load;                                 // New packet enters this cycle
   logic  next_ww;                              // Incoming is a word write
   logic  prev_ww;                              // Last sent was a word write
   addr_t prev_addr;                            // Last sent dstaddr
   logic  last_ww;                              // Tracked word-write flag
   addr_t last_addr;                            // Tracked dstaddr

   // Writes and responses wait on wr, read requests on rd
   assign drain = tx_valid & (tx_packet.write ? tx_wr_ready : tx_rd_ready);

   // Nothing enters while transmit is off
   assign remap_ready = tx_enable & (~tx_valid | drain);
   assign load        = remap_valid & remap_ready;

   assign next_ww = remap_item.pkt.write & (remap_item.pkt.datamode == DATAMODE_WORD);

   // Packet draining now counts as the previous one
   assign prev_ww   = drain ? (tx_packet.write & (tx_packet.datamode == DATAMODE_WORD))
                            : last_ww;
   assign prev_addr = drain ? tx_packet.dstaddr : last_addr;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_valid <= 1'b0;
         tx_burst <= 1'b0;
         last_ww  <= 1'b0;
      end else begin
         if (remap_ready) begin
            tx_valid <= remap_valid;
         end else if (drain) begin
            tx_valid <= 1'b0;                   // Emptied while disabled
         end
         if (load) begin
            tx_burst <= next_ww & prev_ww
                      & (remap_item.pkt.dstaddr == prev_addr + BURST_STEP);
         end
         if (drain) begin
            last_ww <= tx_packet.write & (tx_packet.datamode == DATAMODE_WORD);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         tx_packet <= remap_item.pkt;           // is_rr ends here
      end
      if (drain) begin
         last_addr <= tx_packet.dstaddr;
      end
   end

endmodule

// File: hw/etx_remap.sv
`timescale 1ns/10ps

module etx_remap
   import etx_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   // From etx_cfg
   input  logic      cfg_item_valid,
   input  etx_item_t cfg_item,
   output logic      cfg_item_ready,
   // Remap settings
   input  logic      remap_enable,
   input  addr_t     remap_mask,
   input  addr_t     remap_pat,
   // Toward the protocol stage
   output logic      remap_valid,
   output etx_item_t remap_item,
   input  logic      remap_ready
);

   etx_item_t remap_next;                       // Item after address rewrite

   assign cfg_item_ready = ~remap_valid | remap_ready;

   // Responses go back to the real requester untouched
   always_comb begin
      remap_next = cfg_item;
      if (remap_enable & ~cfg_item.is_rr) begin
         remap_next.pkt.dstaddr = (cfg_item.pkt.dstaddr & ~remap_mask)
                                | (remap_pat & remap_mask);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         remap_valid <= 1'b0;
      end else if (cfg_item_ready) begin
         remap_valid <= cfg_item_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (cfg_item_valid & cfg_item_ready) begin
         remap_item <= remap_next;              // Payload, no reset
      end
   end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the etx_core testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module etx_core_tb -f flist.f -o etx_core_sim \
   && ./obj_dir/etx_core_sim | tee /dev/stderr | grep -Fqx "ALL TESTS PASSED" \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed"; exit 1; }

// File: test/etx_core_tb.sv
`timescale 1ns/10ps

module etx_core_tb
   import etx_pkg::*;
();

   localparam logic [11:0] ID         = 12'h810;             // Core ID under test
   localparam addr_t       BURST_STEP = 32'd4;
   localparam int          PERIOD     = 40;                  // Clock period in ns
   localparam int          N_TRAFFIC  = 200;                 // Packets per random phase
   localparam int          N_TRANS    = 2 * N_TRAFFIC + 30;  // Planned transactions

   logic        clk = 1'b0;
   logic        rst_n;
   logic        txwr_valid, txrd_valid, txrr_valid;
   logic        txwr_ready, txrd_ready, txrr_ready;
   etx_packet_t txwr_packet, txrd_packet, txrr_packet;
   logic        tx_valid, tx_burst, tx_wr_ready, tx_rd_ready;
   etx_packet_t tx_packet;
   logic        cfg_valid, cfg_ready;
   etx_packet_t cfg_packet;

   integer      seed   = 32'h7fc1_0d04;
   int          wr_acc = 0;                                  // Accepts per channel
   int          rd_acc = 0;
   int          rr_acc = 0;

   // Reference copy of the register file
   logic        m_en    = 1'b0;
   logic        m_remap = 1'b0;
   logic        m_ovr   = 1'b0;
   ctrlmode_t   m_mode  = '0;
   addr_t       m_mask  = '0;
   addr_t       m_pat   = '0;
   data_t       m_count = '0;
   etx_packet_t exp_tx[$];                                   // Link packets in order
   etx_packet_t exp_cfg[$];                                  // Register read responses

   // Link side history
   logic        last_ww    = 1'b0;                           // Last transfer a word write
   addr_t       last_dst   = '0;
   logic        tx_held    = 1'b0;                           // Stalled in the last cycle
   logic        cfg_held   = 1'b0;
   logic        burst_prev = 1'b0;
   etx_packet_t tx_prev, cfg_prev;
   int          burst_seen = 0;

   etx_core #(.ID(ID), .BURST_STEP(BURST_STEP)) etx_core_i (.*);

   always #(PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] rand32();
      return $random(seed);
   endfunction

   function automatic addr_t reg_addr(input reg_idx_t idx);
      return {ID, CFG_REGION, 12'h000, idx, 2'b00};
   endfunction

   function automatic logic in_reg_space(input addr_t a);
      return (a[31:20] == ID) && (a[19:16] == CFG_REGION);
   endfunction

   function automatic etx_packet_t random_packet(input logic write);
      etx_packet_t p;
      logic [31:0] r;
      r          = rand32();
      p.write    = write;
      p.datamode = r[0] ? DATAMODE_WORD : r[2:1];            // Mostly words
      p.ctrlmode = r[6:3];
      p.dstaddr  = rand32();
      p.data     = rand32();
      p.srcaddr  = rand32();
      if (in_reg_space(p.dstaddr)) begin
         p.dstaddr[16] = ~p.dstaddr[16];                     // Out of the register space
      end
      return p;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   // Apply one channel acceptance to the register model and expected queues
   task automatic accept_packet(input etx_packet_t p, input logic is_rr);
      etx_packet_t q;
      data_t       value;
      q = p;
      if (m_ovr) begin
         q.ctrlmode = m_mode;                                // Forced on every channel
      end
      if (!is_rr && in_reg_space(p.dstaddr)) begin
         case (p.dstaddr[3:2])
            REG_CTRL:       value = {24'b0, m_mode, 1'b0, m_ovr, m_remap, m_en};
            REG_REMAP_MASK: value = m_mask;
            REG_REMAP_PAT:  value = m_pat;
            default:        value = m_count;
         endcase
         if (p.write) begin
            case (p.dstaddr[3:2])
               REG_CTRL: begin
                  m_en    = p.data[0];
                  m_remap = p.data[1];
                  m_ovr   = p.data[2];
                  m_mode  = p.data[7:4];
               end
               REG_REMAP_MASK: m_mask = p.data;
               REG_REMAP_PAT:  m_pat  = p.data;
               default: ;                                    // Count is read only
            endcase
         end else begin
            q.write   = 1'b1;
            q.dstaddr = p.srcaddr;                           // Back to the requester
            q.data    = value;
            exp_cfg.push_back(q);
         end
      end else begin
         m_count = m_count + 32'd1;
         if (m_remap && !is_rr) begin
            q.dstaddr = (p.dstaddr & ~m_mask) | (m_pat & m_mask);
         end
         exp_tx.push_back(q);
      end
   endtask

   // Channel acceptance monitor
   always @(posedge clk) begin
      if (rst_n) begin
         if (txrr_valid && txrr_ready) begin
            accept_packet(txrr_packet, 1'b1);
            rr_acc++;
         end
         if (txwr_valid && txwr_ready) begin
            accept_packet(txwr_packet, 1'b0);
            wr_acc++;
         end
         if (txrd_valid && txrd_ready) begin
            accept_packet(txrd_packet, 1'b0);
            rd_acc++;
         end
      end
   end

   // Priority, enable gating, link and cfg port checks
   always @(posedge clk) begin
      logic        tx_xfer;
      logic        exp_burst;
      etx_packet_t exp;
      if (rst_n) begin
         assert ($onehot0({txrr_ready, txwr_ready, txrd_ready}))
            else stop_on_error("More than one channel ready was high at once");
         assert (!(txrr_valid && (txwr_ready || txrd_ready)))
            else stop_on_error("A lower channel got ready while a read response waited");
         assert (!(txwr_valid && !txrr_valid && txrd_ready))
            else stop_on_error("The read channel got ready while a write waited");
         assert (m_en || !tx_valid)
            else stop_on_error("A packet appeared on the link while transmit was disabled");
         if (tx_held) begin
            assert (tx_valid && tx_packet == tx_prev && tx_burst == burst_prev)
               else stop_on_error("A stalled link packet changed or vanished");
         end
         tx_xfer = tx_valid && (tx_packet.write ? tx_wr_ready : tx_rd_ready);
         if (tx_xfer) begin
            assert (exp_tx.size() > 0)
               else stop_on_error("A packet left the link that was never sent");
            exp       = exp_tx.pop_front();
            exp_burst = exp.write && (exp.datamode == DATAMODE_WORD) && last_ww
                        && (exp.dstaddr == last_dst + BURST_STEP);
            assert (tx_packet == exp)
               else stop_on_error($sformatf("ERR %0t: tx_packet %h, expected %h",
                                            $time, tx_packet, exp));
            assert (tx_burst == exp_burst)
               else stop_on_error($sformatf("ERR %0t: tx_burst %b, expected %b",
                                            $time, tx_burst, exp_burst));
            last_ww  = exp.write && (exp.datamode == DATAMODE_WORD);
            last_dst = exp.dstaddr;
            if (tx_burst) begin
               burst_seen++;
            end
         end
         tx_held    = tx_valid && !tx_xfer;
         tx_prev    = tx_packet;
         burst_prev = tx_burst;
         if (cfg_held) begin
            assert (cfg_valid && cfg_packet == cfg_prev)
               else stop_on_error("A stalled register response changed or vanished");
         end
         if (cfg_valid && cfg_ready) begin
            assert (exp_cfg.size() > 0)
               else stop_on_error("A register response came out with no read pending");
            exp = exp_cfg.pop_front();
            assert (cfg_packet == exp)
               else stop_on_error($sformatf("ERR %0t: cfg_packet %h, expected %h",
                                            $time, cfg_packet, exp));
         end
         cfg_held = cfg_valid && !cfg_ready;
         cfg_prev = cfg_packet;
      end
   end

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         txwr_valid = 1'b0;
         txrd_valid = 1'b0;
         txrr_valid = 1'b0;
      end
   endtask

   // Offer a packet and return on the edge that takes it
   task automatic put_wr(input etx_packet_t p);
      @(negedge clk);
      txwr_packet = p;
      txwr_valid  = 1'b1;
      @(posedge clk);
      while (!txwr_ready) @(posedge clk);
   endtask

   task automatic put_rd(input etx_packet_t p);
      @(negedge clk);
      txrd_packet = p;
      txrd_valid  = 1'b1;
      @(posedge clk);
      while (!txrd_ready) @(posedge clk);
   endtask

   task automatic wait_drain();
      @(negedge clk);
      tx_wr_ready = 1'b1;
      tx_rd_ready = 1'b1;
      cfg_ready   = 1'b1;
      while (exp_tx.size() != 0 || exp_cfg.size() != 0) @(negedge clk);
      idle(2);
   endtask

   task automatic reg_write(input reg_idx_t idx, input data_t value);
      etx_packet_t p;
      p          = random_packet(1'b1);
      p.datamode = DATAMODE_WORD;
      p.dstaddr  = reg_addr(idx);
      p.data     = value;
      put_wr(p);
      idle(4);                                               // Settle before new traffic
   endtask

   task automatic reg_read(input reg_idx_t idx);
      etx_packet_t p;
      p         = random_packet(1'b0);
      p.dstaddr = reg_addr(idx);
      @(negedge clk);
      cfg_ready = 1'b0;                                      // Response waits a few cycles
      put_rd(p);
      idle(3);
      wait_drain();
   endtask

   // Random traffic on all three channels with random link readies
   task automatic run_traffic(input int n);
      int          issued;
      int          wr_seen, rd_seen, rr_seen;
      logic [31:0] r;
      issued  = 0;
      wr_seen = wr_acc;
      rd_seen = rd_acc;
      rr_seen = rr_acc;
      while (issued < n || txwr_valid || txrd_valid || txrr_valid) begin
         @(negedge clk);
         r           = rand32();
         tx_wr_ready = r[0];
         tx_rd_ready = r[1] | r[2];
         cfg_ready   = r[3];
         if (wr_acc != wr_seen) begin
            txwr_valid = 1'b0;
            wr_seen    = wr_acc;
         end
         if (rd_acc != rd_seen) begin
            txrd_valid = 1'b0;
            rd_seen    = rd_acc;
         end
         if (rr_acc != rr_seen) begin
            txrr_valid = 1'b0;
            rr_seen    = rr_acc;
         end
         if (!txrr_valid && issued < n && r[5:4] == 2'b00) begin
            txrr_packet = random_packet(1'b1);
            if (r[6]) begin
               txrr_packet.dstaddr = reg_addr(r[8:7]);       // Must pass undecoded
            end
            txrr_valid = 1'b1;
            issued++;
         end
         if (!txwr_valid && issued < n && r[9]) begin
            txwr_packet = random_packet(1'b1);
            txwr_valid  = 1'b1;
            issued++;
         end
         if (!txrd_valid && issued < n && r[10]) begin
            txrd_packet = random_packet(1'b0);
            txrd_valid  = 1'b1;
            issued++;
         end
      end
   endtask

   initial begin
      etx_packet_t p;
      addr_t       base;
      rst_n       = 1'b0;
      txwr_valid  = 1'b0;
      txrd_valid  = 1'b0;
      txrr_valid  = 1'b0;
      txwr_packet = '0;
      txrd_packet = '0;
      txrr_packet = '0;
      tx_wr_ready = 1'b0;
      tx_rd_ready = 1'b0;
      cfg_ready   = 1'b0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      assert (!tx_valid && !cfg_valid)
         else stop_on_error("tx_valid or cfg_valid was high after reset");

      // Two writes park in the pipeline until transmit is on
      tx_wr_ready = 1'b1;
      tx_rd_ready = 1'b1;
      cfg_ready   = 1'b1;
      put_wr(random_packet(1'b1));
      put_wr(random_packet(1'b1));
      idle(20);
      reg_write(REG_CTRL, 32'h0000_0001);
      wait_drain();

      reg_write(REG_REMAP_MASK, rand32() | 32'h0000_ff00);
      reg_write(REG_REMAP_PAT, rand32());
      reg_read(REG_CTRL);
      reg_read(REG_REMAP_MASK);
      reg_read(REG_REMAP_PAT);
      reg_read(REG_COUNT);

      run_traffic(N_TRAFFIC);
      wait_drain();
      reg_read(REG_COUNT);

      // Remap plus forced ctrlmode A
      reg_write(REG_REMAP_MASK, rand32() | 32'h00ff_0000);
      reg_write(REG_CTRL, 32'h0000_00a7);
      run_traffic(N_TRAFFIC);
      wait_drain();
      reg_read(REG_CTRL);

      // Four stepped word writes, a jump, then one more step
      reg_write(REG_CTRL, 32'h0000_0001);
      base = rand32() & 32'hfff0_ff00;
      for (int i = 0; i < 6; i++) begin
         p          = random_packet(1'b1);
         p.datamode = DATAMODE_WORD;
         p.dstaddr  = base + ((i < 4) ? i * BURST_STEP : 32'h100 + (i - 4) * BURST_STEP);
         put_wr(p);
      end
      idle(1);
      wait_drain();
      assert (burst_seen >= 4)
         else stop_on_error("The burst flag did not show on the stepped writes");
      reg_read(REG_COUNT);
      $display("ALL TESTS PASSED");
      $finish;
   end

   // Watchdog sized from the planned transaction count
   initial begin
      #(N_TRANS * 50 * PERIOD);
      $display("Watchdog expired before the tests finished, the DUT stopped moving");
      $display("SOME TESTS FAILED");
      $fatal(1, "Timeout");
   end

endmodule
